// ==== mboxWordPkg.sv ====
// machine word types, widths and parity helper shared by the memory buffer RTL and its testbench
package mboxWordPkg;

  // full 36-bit word and its halves
  localparam int wordW = 36;
  localparam int halfW = 18;

  typedef logic [wordW-1:0] wordT;

  // channel buffer entry keeps the parity computed at write time
  // next to the data, so a later read can be checked against it
  typedef struct packed {
    logic par;
    wordT data;
  } chEntryT;

  // reduction xor over the word
  // 1 when the word holds an odd number of ones
  function automatic logic oddParity(input wordT w);
    return ^w;
  endfunction

endpackage

// ==== mboxCtlPkg.sv ====
// select encodings and buffer sizes used by the memory buffer control inputs
package mboxCtlPkg;

  // number of memory buffer slots
  localparam int mbCount = 4;

  // channel command word buffer entries
  localparam int ccwDepth = 4;

  // source of the word loaded into an MB slot
  typedef enum logic [1:0] {
    srcCache  = 2'd0,
    // ar, or the channel buffer word when inSelChBuf is set
    srcArOrCh = 2'd1,
    srcMem    = 2'd2,
    srcCcw    = 2'd3
  } mbSrcT;

  // source of the word sent from memory toward the cache
  typedef enum logic [1:0] {
    mtcAr    = 2'd0,
    mtcMb    = 2'd1,
    mtcMem   = 2'd2,
    mtcChReg = 2'd3
  } memToCacheSelT;

endpackage

// ==== wordRam.sv ====
// single-port RAM with synchronous write and registered read address, payload set by type parameter
module wordRam #(
  parameter type payloadT = mboxWordPkg::wordT,
  parameter int  depth    = 128
) (
  input  logic                     MBOX,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] adr,
  input  payloadT                  wrData,
  output payloadT                  rdData
);

  payloadT mem [depth];

  // address captured every edge
  logic [$clog2(depth)-1:0] adrQ;

  always_ff @(posedge MBOX) begin
    if (we) begin
      mem[adr] <= wrData;
    end
    adrQ <= adr;
  end

  // read data follows the captured address
  // a write and a read of the same slot show the new entry next cycle
  assign rdData = mem[adrQ];

endmodule

// ==== mbSourceMux.sv ====
// Wishbone slave for memory words and MB input source selection with nxm load squash
module mbSourceMux (
  input  logic                    MBOX,
  input  logic                    arstN,
  // Wishbone classic slave
  input  logic                    wbCyc,
  input  logic                    wbStb,
  input  logic                    wbWe,
  input  logic                    wbAdr,
  input  mboxWordPkg::wordT       wbDatW,
  output mboxWordPkg::wordT       wbDatR,
  output logic                    wbAck,
  // current MB word, returned on reads of address 1
  input  mboxWordPkg::wordT       mb,
  // candidate source words
  input  mboxWordPkg::wordT       cacheData,
  input  mboxWordPkg::wordT       ar,
  input  mboxWordPkg::wordT       mbChBuf,
  input  mboxWordPkg::wordT       ccwMix,
  input  mboxCtlPkg::mbSrcT       mbInSel,
  input  logic                    inSelChBuf,
  input  logic                    nxm,
  input  logic [mboxCtlPkg::mbCount-1:0] mbLoadReq,
  output mboxWordPkg::wordT       memData,
  output mboxWordPkg::wordT       mbIn,
  output logic [mboxCtlPkg::mbCount-1:0] mbLoad
);

  // set once an access is acked, cleared when stb drops
  logic wbDone;

  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      wbAck   <= 1'b0;
      wbDone  <= 1'b0;
      wbDatR  <= '0;
      memData <= '0;
    end else begin
      wbAck <= 1'b0;
      if (!wbStb) begin
        wbDone <= 1'b0;
      end
      if (wbCyc && wbStb && !wbDone) begin
        wbAck  <= 1'b1;
        wbDone <= 1'b1;
        // write to address 0 lands in the memory data register
        if (wbWe && !wbAdr) begin
          memData <= wbDatW;
        end
        // read of address 1 returns MB, everything else reads zero
        wbDatR <= (!wbWe && wbAdr) ? mb : '0;
      end
    end
  end

  // MB input source
  always_comb begin
    mbIn = '0;
    case (mbInSel)
      mboxCtlPkg::srcCache:  mbIn = cacheData;
      mboxCtlPkg::srcArOrCh: mbIn = inSelChBuf ? mbChBuf : ar;
      mboxCtlPkg::srcMem:    mbIn = memData;
      mboxCtlPkg::srcCcw:    mbIn = ccwMix;
      default:               mbIn = '0;
    endcase
  end

  // no slot loads on a nonexistent memory reference
  assign mbLoad = nxm ? '0 : mbLoadReq;

endmodule

// ==== mbRegFile.sv ====
// four memory buffer registers with independent loads, holdable slot select and odd parity output
module mbRegFile (
  input  logic                              MBOX,
  input  logic                              arstN,
  input  mboxWordPkg::wordT                 mbIn,
  input  logic [mboxCtlPkg::mbCount-1:0]    mbLoad,
  input  logic [$clog2(mboxCtlPkg::mbCount)-1:0] mbSelIn,
  input  logic                              mbSelHold,
  output mboxWordPkg::wordT                 mb,
  output logic                              mbParOdd
);

  localparam int selW = $clog2(mboxCtlPkg::mbCount);

  mboxWordPkg::wordT mbSlot [mboxCtlPkg::mbCount];

  logic [selW-1:0] mbSel;

  // each slot loads from the shared input word on its own enable
  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < mboxCtlPkg::mbCount; i++) begin
        mbSlot[i] <= '0;
      end
    end else begin
      for (int i = 0; i < mboxCtlPkg::mbCount; i++) begin
        if (mbLoad[i]) begin
          mbSlot[i] <= mbIn;
        end
      end
    end
  end

  // select register
  // hold keeps the current slot on the output
  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      mbSel <= '0;
    end else if (!mbSelHold) begin
      mbSel <= mbSelIn;
    end
  end

  assign mb = mbSlot[mbSel];

  // parity over whatever slot is on the bus
  assign mbParOdd = mboxWordPkg::oddParity(mb);

endmodule

// ==== chanPath.sv ====
// channel register, channel buffer with parity, CCW buffer, memory-to-cache mux and held cache-bus output
module chanPath #(
  parameter int chBufDepth = 128
) (
  input  logic                          MBOX,
  input  logic                          arstN,
  input  mboxWordPkg::wordT             mb,
  input  mboxWordPkg::wordT             ar,
  input  mboxWordPkg::wordT             memData,
  // channel register
  input  mboxWordPkg::wordT             cbusIn,
  input  logic                          chReverse,
  input  logic                          chT2,
  input  logic                          chT0,
  // channel buffer
  input  logic                          bufMbSel,
  input  logic                          chBufWr,
  input  logic [$clog2(chBufDepth)-1:0] chBufAdr,
  // CCW buffer
  input  mboxWordPkg::wordT             ccwBufIn,
  input  logic [$clog2(mboxCtlPkg::ccwDepth)-1:0] ccwBufAdr,
  input  logic                          ccwBufWr,
  input  logic                          mixMbSel,
  // memory to cache
  input  logic                          memToCacheEn,
  input  mboxCtlPkg::memToCacheSelT     memToCacheSel,
  input  logic                          cbusOutHold,
  output mboxWordPkg::wordT             mbChBuf,
  output mboxWordPkg::wordT             ccwMix,
  output mboxWordPkg::wordT             memToCache,
  output mboxWordPkg::wordT             cbusOut,
  output logic                          chBufParErr
);

  localparam int halfW = mboxWordPkg::halfW;

  logic                  chT2Q;
  mboxWordPkg::wordT     chReg;
  mboxWordPkg::wordT     chBufWord;
  mboxWordPkg::chEntryT  chBufWrEntry;
  mboxWordPkg::chEntryT  chBufRdEntry;
  mboxWordPkg::wordT     ccwBuf [mboxCtlPkg::ccwDepth];

  // channel register
  // the strobe is delayed one edge, so data lands two edges after chT2
  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      chT2Q <= 1'b0;
      chReg <= '0;
    end else begin
      chT2Q <= chT2;
      if (chT2Q) begin
        chReg <= chReverse ? {cbusIn[halfW-1:0], cbusIn[2*halfW-1:halfW]} : cbusIn;
      end
    end
  end

  // channel buffer write word and its parity
  assign chBufWord          = bufMbSel ? chReg : mb;
  assign chBufWrEntry.data  = chBufWord;
  assign chBufWrEntry.par   = mboxWordPkg::oddParity(chBufWord);

  wordRam #(
    .payloadT (mboxWordPkg::chEntryT),
    .depth    (chBufDepth)
  ) chBuf_i (
    .MBOX   (MBOX),
    .we     (chBufWr),
    .adr    (chBufAdr),
    .wrData (chBufWrEntry),
    .rdData (chBufRdEntry)
  );

  // stored parity against a fresh check of the data read back
  assign chBufParErr = chBufRdEntry.par != mboxWordPkg::oddParity(chBufRdEntry.data);

  // buffer word toward the MB source mux, and the held cache bus copy
  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      mbChBuf <= '0;
      cbusOut <= '0;
    end else begin
      if (chT0) begin
        mbChBuf <= chBufRdEntry.data;
      end
      if (!cbusOutHold) begin
        cbusOut <= chBufRdEntry.data;
      end
    end
  end

  // CCW buffer, written on the edge and read combinationally
  always_ff @(posedge MBOX) begin
    if (ccwBufWr) begin
      ccwBuf[ccwBufAdr] <= ccwBufIn;
    end
  end

  assign ccwMix = mixMbSel ? mb : ccwBuf[ccwBufAdr];

  // memory to cache, zero while not enabled
  always_comb begin
    memToCache = '0;
    if (memToCacheEn) begin
      case (memToCacheSel)
        mboxCtlPkg::mtcAr:    memToCache = ar;
        mboxCtlPkg::mtcMb:    memToCache = mb;
        mboxCtlPkg::mtcMem:   memToCache = memData;
        mboxCtlPkg::mtcChReg: memToCache = chReg;
        default:              memToCache = '0;
      endcase
    end
  end

endmodule

// ==== memBufTop.sv ====
// memory buffer top level joining the source mux, the MB register file and the channel path
module memBufTop #(
  parameter int chBufDepth = 128
) (
  input  logic                          MBOX,
  input  logic                          arstN,
  // Wishbone classic slave
  input  logic                          wbCyc,
  input  logic                          wbStb,
  input  logic                          wbWe,
  input  logic                          wbAdr,
  input  mboxWordPkg::wordT             wbDatW,
  output mboxWordPkg::wordT             wbDatR,
  output logic                          wbAck,
  // MB input side
  input  mboxWordPkg::wordT             cacheData,
  input  mboxWordPkg::wordT             ar,
  input  mboxCtlPkg::mbSrcT             mbInSel,
  input  logic                          inSelChBuf,
  input  logic                          nxm,
  input  logic [mboxCtlPkg::mbCount-1:0] mbLoadReq,
  input  logic [$clog2(mboxCtlPkg::mbCount)-1:0] mbSelIn,
  input  logic                          mbSelHold,
  output mboxWordPkg::wordT             mb,
  output logic                          mbParOdd,
  // channel side
  input  mboxWordPkg::wordT             cbusIn,
  input  logic                          chReverse,
  input  logic                          chT2,
  input  logic                          chT0,
  input  logic                          bufMbSel,
  input  logic                          chBufWr,
  input  logic [$clog2(chBufDepth)-1:0] chBufAdr,
  input  mboxWordPkg::wordT             ccwBufIn,
  input  logic [$clog2(mboxCtlPkg::ccwDepth)-1:0] ccwBufAdr,
  input  logic                          ccwBufWr,
  input  logic                          mixMbSel,
  input  logic                          memToCacheEn,
  input  mboxCtlPkg::memToCacheSelT     memToCacheSel,
  input  logic                          cbusOutHold,
  output mboxWordPkg::wordT             memToCache,
  output mboxWordPkg::wordT             cbusOut,
  output logic                          chBufParErr
);

  // links between the stages
  mboxWordPkg::wordT                memData;
  mboxWordPkg::wordT                mbIn;
  logic [mboxCtlPkg::mbCount-1:0]   mbLoad;
  mboxWordPkg::wordT                mbChBuf;
  mboxWordPkg::wordT                ccwMix;

  mbSourceMux mbSourceMux_i (
    .MBOX       (MBOX),
    .arstN      (arstN),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbDatW     (wbDatW),
    .wbDatR     (wbDatR),
    .wbAck      (wbAck),
    .mb         (mb),
    .cacheData  (cacheData),
    .ar         (ar),
    .mbChBuf    (mbChBuf),
    .ccwMix     (ccwMix),
    .mbInSel    (mbInSel),
    .inSelChBuf (inSelChBuf),
    .nxm        (nxm),
    .mbLoadReq  (mbLoadReq),
    .memData    (memData),
    .mbIn       (mbIn),
    .mbLoad     (mbLoad)
  );

  mbRegFile mbRegFile_i (
    .MBOX      (MBOX),
    .arstN     (arstN),
    .mbIn      (mbIn),
    .mbLoad    (mbLoad),
    .mbSelIn   (mbSelIn),
    .mbSelHold (mbSelHold),
    .mb        (mb),
    .mbParOdd  (mbParOdd)
  );

  chanPath #(
    .chBufDepth (chBufDepth)
  ) chanPath_i (
    .MBOX          (MBOX),
    .arstN         (arstN),
    .mb            (mb),
    .ar            (ar),
    .memData       (memData),
    .cbusIn        (cbusIn),
    .chReverse     (chReverse),
    .chT2          (chT2),
    .chT0          (chT0),
    .bufMbSel      (bufMbSel),
    .chBufWr       (chBufWr),
    .chBufAdr      (chBufAdr),
    .ccwBufIn      (ccwBufIn),
    .ccwBufAdr     (ccwBufAdr),
    .ccwBufWr      (ccwBufWr),
    .mixMbSel      (mixMbSel),
    .memToCacheEn  (memToCacheEn),
    .memToCacheSel (memToCacheSel),
    .cbusOutHold   (cbusOutHold),
    .mbChBuf       (mbChBuf),
    .ccwMix        (ccwMix),
    .memToCache    (memToCache),
    .cbusOut       (cbusOut),
    .chBufParErr   (chBufParErr)
  );

endmodule

// ==== memBufTop_props.sv ====
// concurrent checks on the Wishbone handshake, nxm squash and output state, bound into memBufTop
module memBufProps (
  input logic                           MBOX,
  input logic                           arstN,
  input logic                           wbCyc,
  input logic                           wbStb,
  input logic                           wbAck,
  input logic                           nxm,
  input logic [mboxCtlPkg::mbCount-1:0] mbLoad,
  input mboxWordPkg::wordT              wbDatR,
  input mboxWordPkg::wordT              mb,
  input logic                           mbParOdd,
  input mboxWordPkg::wordT              memToCache,
  input mboxWordPkg::wordT              cbusOut,
  input logic                           chBufParErr
);

  ackInCycle: assert property (@(posedge MBOX) disable iff (!arstN) wbAck |-> wbCyc && wbStb)
    else $error("wbAck outside an active cycle");

  ackSingle: assert property (@(posedge MBOX) disable iff (!arstN) wbAck |=> !wbAck)
    else $error("wbAck high two cycles running");

  nxmSquash: assert property (@(posedge MBOX) disable iff (!arstN) nxm |-> mbLoad == '0)
    else $error("slot load while nxm is high");

  outKnown: assert property (@(posedge MBOX) disable iff (!arstN)
    !$isunknown({wbAck, wbDatR, mb, mbParOdd, memToCache, cbusOut, chBufParErr}))
    else $error("unknown value on an output");

endmodule

bind memBufTop memBufProps memBufProps_i (.*);

// ==== memBufTb.sv ====
// self-checking testbench for memBufTop, run as the simulation top with the bound property module
module memBufTb;

  localparam int chBufDepth = 128;
  localparam int adrW = $clog2(chBufDepth);
  localparam int ackLimit = 20;

  logic MBOX;
  logic arstN;
  logic wbCyc, wbStb, wbWe, wbAdr, wbAck;
  mboxWordPkg::wordT wbDatW, wbDatR;
  mboxWordPkg::wordT cacheData, ar, mb, cbusIn, ccwBufIn, memToCache, cbusOut;
  mboxCtlPkg::mbSrcT mbInSel;
  mboxCtlPkg::memToCacheSelT memToCacheSel;
  logic inSelChBuf, nxm, mbSelHold, mbParOdd;
  logic [3:0] mbLoadReq;
  logic [1:0] mbSelIn, ccwBufAdr;
  logic chReverse, chT2, chT0, bufMbSel, chBufWr, ccwBufWr, mixMbSel;
  logic memToCacheEn, cbusOutHold, chBufParErr;
  logic [adrW-1:0] chBufAdr;

  // reference state
  mboxWordPkg::wordT mSlot [4];
  logic [1:0] mSel;
  mboxWordPkg::wordT mMemData, mChReg, mMbChBuf, mCbus;
  logic mChT2Q;
  mboxWordPkg::wordT mChBuf [chBufDepth];
  mboxWordPkg::wordT mCcw [4];
  logic [adrW-1:0] mAdrQ;

  integer seed = 81;
  int errors = 0;
  int checks = 0;
  int timeouts = 0;

  memBufTop #(.chBufDepth(chBufDepth)) memBufTop_i (.*);

  always #5 MBOX = ~MBOX;

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic mboxWordPkg::wordT randWord();
    logic [63:0] r;
    r = {rnd(), rnd()};
    return r[35:0];
  endfunction

  function automatic mboxWordPkg::wordT expMb();
    return mSlot[mSel];
  endfunction

  function automatic mboxWordPkg::wordT swapRef(mboxWordPkg::wordT w, logic rev);
    return rev ? {w[17:0], w[35:18]} : w;
  endfunction

  function automatic mboxWordPkg::wordT ccwMixRef();
    return mixMbSel ? expMb() : mCcw[ccwBufAdr];
  endfunction

  // word offered to the MB slots for the current source select
  function automatic mboxWordPkg::wordT srcRef();
    case (mbInSel)
      mboxCtlPkg::srcCache:  return cacheData;
      mboxCtlPkg::srcArOrCh: return inSelChBuf ? mMbChBuf : ar;
      mboxCtlPkg::srcMem:    return mMemData;
      default:               return ccwMixRef();
    endcase
  endfunction

  function automatic mboxWordPkg::wordT mtcRef();
    if (!memToCacheEn) return '0;
    case (memToCacheSel)
      mboxCtlPkg::mtcAr:  return ar;
      mboxCtlPkg::mtcMb:  return expMb();
      mboxCtlPkg::mtcMem: return mMemData;
      default:            return mChReg;
    endcase
  endfunction

  // reference model, advanced on every rising edge from pre-edge state
  always @(posedge MBOX) begin
    mboxWordPkg::wordT rd;
    mboxWordPkg::wordT nextIn;
    rd = mChBuf[mAdrQ];
    nextIn = srcRef();
    // memories ignore reset
    if (chBufWr) mChBuf[chBufAdr] = bufMbSel ? mChReg : expMb();
    mAdrQ = chBufAdr;
    if (ccwBufWr) mCcw[ccwBufAdr] = ccwBufIn;
    if (!arstN) begin
      for (int i = 0; i < 4; i++) mSlot[i] = '0;
      mSel = '0;
      mChT2Q = 1'b0;
      mChReg = '0;
      mMbChBuf = '0;
      mCbus = '0;
    end else begin
      if (mChT2Q) mChReg = swapRef(cbusIn, chReverse);
      mChT2Q = chT2;
      if (chT0) mMbChBuf = rd;
      if (!cbusOutHold) mCbus = rd;
      for (int i = 0; i < 4; i++) begin
        if (mbLoadReq[i] && !nxm) mSlot[i] = nextIn;
      end
      if (!mbSelHold) mSel = mbSelIn;
    end
  end

  task automatic checkEq(string name, mboxWordPkg::wordT got, mboxWordPkg::wordT exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // comparison process, after the edge has settled
  always @(posedge MBOX) begin
    #1;
    if (arstN) begin
      checkEq("mb", mb, expMb());
      checkEq("mbParOdd", 36'(mbParOdd), 36'(^expMb()));
      checkEq("memToCache", memToCache, mtcRef());
      checkEq("cbusOut", cbusOut, mCbus);
      checkEq("chBufParErr", 36'(chBufParErr), '0);
    end
  end

  task automatic timeoutFail();
    timeouts++;
    $display("timeout: no wbAck within %0d cycles", ackLimit);
    $display("errors %0d, timeouts %0d, checks %0d", errors, timeouts, checks);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // one classic Wishbone access, stb held through the edge that samples ack
  task automatic wbAccess(input logic we, input logic adr, input mboxWordPkg::wordT dat,
                          input mboxWordPkg::wordT expRd);
    int n;
    n = 0;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = adr;
    wbDatW = dat;
    @(negedge MBOX);
    while (!wbAck && n < ackLimit) begin
      @(negedge MBOX);
      n++;
    end
    if (!wbAck) begin
      timeoutFail();
    end else begin
      if (we && !adr) mMemData = dat;
      checkEq("wbDatR", wbDatR, expRd);
      @(negedge MBOX);
      checks++;
      assert (!wbAck) else begin
        errors++;
        $display("wbAck stayed high for a second cycle");
      end
      wbStb = 1'b0;
      wbCyc = 1'b0;
      @(negedge MBOX);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [adrW-1:0] a;
    MBOX = 1'b0;
    arstN = 1'b0;
    {wbCyc, wbStb, wbWe, wbAdr} = '0;
    wbDatW = '0;
    cacheData = '0;
    ar = '0;
    cbusIn = '0;
    ccwBufIn = '0;
    mbInSel = mboxCtlPkg::srcCache;
    memToCacheSel = mboxCtlPkg::mtcAr;
    {inSelChBuf, nxm, mbSelHold, chReverse, chT2, chT0, bufMbSel} = '0;
    {ccwBufWr, mixMbSel, memToCacheEn, cbusOutHold} = '0;
    mbLoadReq = '0;
    mbSelIn = '0;
    ccwBufAdr = '0;
    chBufAdr = '0;
    mMemData = '0;
    mAdrQ = '0;
    for (int i = 0; i < chBufDepth; i++) mChBuf[i] = '0;
    // entry 0 is cleared while reset is held
    chBufWr = 1'b1;
    repeat (5) @(negedge MBOX);
    arstN = 1'b1;
    // clear the rest of the channel buffer and fill the CCW buffer
    for (int i = 1; i < chBufDepth; i++) begin
      chBufAdr = adrW'(i);
      ccwBufWr = i < 5;
      ccwBufAdr = 2'(i - 1);
      ccwBufIn = randWord();
      @(negedge MBOX);
    end
    chBufWr = 1'b0;
    ccwBufWr = 1'b0;

    // Wishbone writes land in memData, reads return MB
    for (int i = 0; i < 4; i++) begin
      wbAccess(1'b1, 1'b0, randWord(), '0);
      // copy memData into a slot and select it for the read back
      mbInSel = mboxCtlPkg::srcMem;
      mbSelIn = 2'(i);
      mbLoadReq = 4'b0001 << i;
      @(negedge MBOX);
      mbLoadReq = '0;
      wbAccess(1'b0, 1'b1, '0, expMb());
      wbAccess(1'b0, 1'b0, '0, '0);
    end
    memToCacheEn = 1'b1;
    memToCacheSel = mboxCtlPkg::mtcMem;

    // random MB loads, with nxm squash and select hold
    for (int i = 0; i < 24; i++) begin
      r = rnd();
      cacheData = randWord();
      ar = randWord();
      mbInSel = mboxCtlPkg::mbSrcT'(r[1:0]);
      inSelChBuf = r[2];
      nxm = r[3];
      mbLoadReq = r[7:4];
      mbSelIn = r[9:8];
      mbSelHold = r[10];
      mixMbSel = r[11];
      ccwBufAdr = r[13:12];
      @(negedge MBOX);
    end
    {nxm, mbSelHold} = '0;
    mbLoadReq = '0;

    // channel register, straight and swapped
    memToCacheSel = mboxCtlPkg::mtcChReg;
    for (int i = 0; i < 6; i++) begin
      cbusIn = randWord();
      chReverse = i[0];
      chT2 = 1'b1;
      @(negedge MBOX);
      chT2 = 1'b0;
      repeat (3) @(negedge MBOX);
    end

    // channel buffer write and read back
    for (int i = 0; i < 8; i++) begin
      r = rnd();
      a = r[adrW-1:0];
      cacheData = randWord();
      mbInSel = mboxCtlPkg::srcCache;
      mbSelIn = 2'd0;
      mbLoadReq = 4'b0001;
      @(negedge MBOX);
      mbLoadReq = '0;
      chBufAdr = a;
      bufMbSel = i[0];
      chBufWr = 1'b1;
      @(negedge MBOX);
      chBufWr = 1'b0;
      cbusOutHold = i[1];
      chT0 = 1'b1;
      repeat (2) @(negedge MBOX);
      chT0 = 1'b0;
      cbusOutHold = 1'b0;
      // move the buffer word into slot 1 to observe it
      mbInSel = mboxCtlPkg::srcArOrCh;
      inSelChBuf = 1'b1;
      mbSelIn = 2'd1;
      mbLoadReq = 4'b0010;
      @(negedge MBOX);
      mbLoadReq = '0;
      inSelChBuf = 1'b0;
      @(negedge MBOX);
    end

    // CCW entries through the MB, then every memory-to-cache select
    for (int i = 0; i < 4; i++) begin
      r = rnd();
      ccwBufAdr = 2'(i);
      ccwBufIn = randWord();
      ccwBufWr = 1'b1;
      @(negedge MBOX);
      ccwBufWr = 1'b0;
      mixMbSel = r[0];
      mbInSel = mboxCtlPkg::srcCcw;
      mbSelIn = 2'(i);
      mbLoadReq = 4'b0001 << i;
      @(negedge MBOX);
      mbLoadReq = '0;
      @(negedge MBOX);
    end
    for (int s = 0; s < 4; s++) begin
      memToCacheSel = mboxCtlPkg::memToCacheSelT'(s);
      @(negedge MBOX);
    end
    memToCacheEn = 1'b0;
    repeat (2) @(negedge MBOX);

    $display("errors %0d, timeouts %0d, checks %0d", errors, timeouts, checks);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== memBuf.f ====
mboxWordPkg.sv
mboxCtlPkg.sv
wordRam.sv
mbSourceMux.sv
mbRegFile.sv
chanPath.sv
memBufTop.sv
memBufTop_props.sv
memBufTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f memBuf.f \
  --top-module memBufTb \
  -o memBufSim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/memBufSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "testbench reported failure"
  exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi

exit 0
